//--- common/eth_loop_pkg.sv
// Ethernet loopback package with GMII and byte-stream types and framing constants
package eth_loop_pkg;

    // One GMII byte lane, the same for receive and transmit
    typedef struct packed {
        logic [7:0] d;
        logic       en;
        logic       er;
    } gmii_t;

    // One frame byte on the internal streams
    typedef struct packed {
        logic [7:0] data;
        // Final byte of the frame
        logic       last;
        // Only meaningful with last, frame gets discarded
        logic       bad;
    } axis_byte_t;

    // Preamble and start-of-frame delimiter
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // Preamble bytes ahead of the delimiter
    localparam int PREAMBLE_LEN = 7;

    // Minimum frame on the wire, FCS included
    localparam int MIN_FRAME_LEN = 64;

    // No FCS is generated here, so the data minimum is the frame minimum less this
    localparam int FCS_LEN = 4;

endpackage

//--- filelist.f
common/eth_loop_pkg.sv
mac_port/gmii_rx_framer.sv
mac_port/frame_fifo.sv
mac_port/gmii_tx_framer.sv
source/eth_loop_core.sv
verification/tb_clock_gen.sv
verification/eth_loop_core_tb.sv

//--- mac_port/frame_fifo.sv
// Store-and-forward frame FIFO that releases only complete good frames
`timescale 1ns/1ps

module frame_fifo #(
    parameter int FIFO_DEPTH = 16384
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  eth_loop_pkg::axis_byte_t rx_stream,
    input  logic                     rx_valid,
    output eth_loop_pkg::axis_byte_t tx_stream,
    output logic                     tx_valid,
    input  logic                     tx_ready
);

    import eth_loop_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    // Stored word, bad frames never get this far
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } fifo_word_t;

    fifo_word_t  mem [FIFO_DEPTH];

    // Extra MSB tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] commit_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] wr_next;
    logic        dropping;
    logic        full;
    logic        wr_en;
    logic        rd_load;

    assign wr_next = wr_ptr + 1'b1;
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Nothing is stored once the current frame has overflowed
    assign wr_en = rx_valid && !full && !dropping;

    // Refill the output register when empty or being taken
    assign rd_load = (!tx_valid || tx_ready) && (rd_ptr != commit_ptr);

    // Write side with tentative and committed pointers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            dropping   <= 1'b0;
        end else if (rx_valid) begin
            if (rx_stream.last) begin
                if (rx_stream.bad || dropping || full) begin
                    // Erase the whole frame
                    wr_ptr   <= commit_ptr;
                    dropping <= 1'b0;
                end else begin
                    wr_ptr     <= wr_next;
                    commit_ptr <= wr_next;
                end
            end else if (dropping || full) begin
                // Ignore the rest of this frame until its end
                dropping <= 1'b1;
            end else begin
                wr_ptr <= wr_next;
            end
        end
    end

    // Read side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            tx_valid <= 1'b0;
        end else if (rd_load) begin
            rd_ptr   <= rd_ptr + 1'b1;
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    // Byte memory and registered read port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= '{data: rx_stream.data, last: rx_stream.last};
        end
        if (rd_load) begin
            tx_stream.data <= mem[rd_ptr[AW-1:0]].data;
            tx_stream.last <= mem[rd_ptr[AW-1:0]].last;
            tx_stream.bad  <= 1'b0;
        end
    end

endmodule

//--- mac_port/gmii_rx_framer.sv
// GMII receive framer that strips preamble and SFD and flags errored or oversize frames
`timescale 1ns/1ps

module gmii_rx_framer #(
    parameter int MAX_FRAME_LEN = 9218
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  eth_loop_pkg::gmii_t      gmii_rx,
    output eth_loop_pkg::axis_byte_t rx_stream,
    output logic                     rx_valid
);

    import eth_loop_pkg::*;

    localparam int LEN_W = $clog2(MAX_FRAME_LEN + 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA
    } rx_state_t;

    rx_state_t        state;
    logic [LEN_W-1:0] len_cnt;
    logic             hold_vld;
    logic [7:0]       hold_data;
    logic             err_flag;
    logic             oversize;
    logic             room;
    logic             load;
    logic             emit;

    // Bytes past the limit are counted as oversize and never held
    assign room = len_cnt < LEN_W'(MAX_FRAME_LEN);
    assign load = (state == RX_DATA) && gmii_rx.en && room;

    // Held byte goes out when a new one replaces it or when en falls
    assign emit = (state == RX_DATA) && hold_vld && (gmii_rx.en ? room : 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            len_cnt  <= '0;
            hold_vld <= 1'b0;
            err_flag <= 1'b0;
            oversize <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= emit;
            case (state)
                RX_IDLE: begin
                    len_cnt  <= '0;
                    hold_vld <= 1'b0;
                    oversize <= 1'b0;
                    err_flag <= gmii_rx.en && gmii_rx.er;
                    if (gmii_rx.en && gmii_rx.d == PREAMBLE_BYTE) begin
                        state <= RX_PREAMBLE;
                    end
                end
                RX_PREAMBLE: begin
                    if (!gmii_rx.en) begin
                        state <= RX_IDLE;
                    end else begin
                        err_flag <= err_flag | gmii_rx.er;
                        if (gmii_rx.d == SFD_BYTE) begin
                            state <= RX_DATA;
                        end
                    end
                end
                RX_DATA: begin
                    if (!gmii_rx.en) begin
                        state <= RX_IDLE;
                    end else begin
                        err_flag <= err_flag | gmii_rx.er;
                        if (room) begin
                            len_cnt  <= len_cnt + 1'b1;
                            hold_vld <= 1'b1;
                        end else begin
                            oversize <= 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Payload path, one byte held back so last can be marked
    always_ff @(posedge clk) begin
        if (load) begin
            hold_data <= gmii_rx.d;
        end
        if (emit) begin
            rx_stream.data <= hold_data;
            rx_stream.last <= !gmii_rx.en;
            rx_stream.bad  <= !gmii_rx.en && (err_flag || oversize);
        end
    end

endmodule

//--- mac_port/gmii_tx_framer.sv
// GMII transmit framer adding preamble and SFD, padding short frames and keeping the IFG
`timescale 1ns/1ps

module gmii_tx_framer #(
    parameter int IFG_BYTES = 12
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  eth_loop_pkg::axis_byte_t tx_stream,
    input  logic                     tx_valid,
    output logic                     tx_ready,
    output eth_loop_pkg::gmii_t      gmii_tx
);

    import eth_loop_pkg::*;

    // Shortest data field, FCS is not appended here
    localparam int MIN_DATA_LEN = MIN_FRAME_LEN - FCS_LEN;
    localparam int CNT_MAX      = (IFG_BYTES > MIN_DATA_LEN) ? IFG_BYTES : MIN_DATA_LEN;
    localparam int CNT_W        = $clog2(CNT_MAX + 1);
    localparam int LEN_W        = $clog2(MIN_DATA_LEN + 1);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_DATA,
        TX_PAD,
        TX_GAP
    } tx_state_t;

    tx_state_t        state;
    // Preamble, pad and gap all count with this one
    logic [CNT_W-1:0] cnt;
    // Data bytes sent, saturates at the minimum
    logic [LEN_W-1:0] len_cnt;
    logic             xfer;
    logic             short_frame;
    logic [CNT_W-1:0] pad_cnt;

    assign xfer        = tx_valid && tx_ready;
    assign short_frame = len_cnt < LEN_W'(MIN_DATA_LEN - 1);
    assign pad_cnt     = CNT_W'(MIN_DATA_LEN - 1) - CNT_W'(len_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            cnt      <= '0;
            len_cnt  <= '0;
            tx_ready <= 1'b0;
            gmii_tx  <= '0;
        end else begin
            gmii_tx.er <= 1'b0;
            case (state)
                TX_IDLE: begin
                    // First preamble byte goes out right away
                    gmii_tx.d  <= PREAMBLE_BYTE;
                    gmii_tx.en <= tx_valid;
                    if (tx_valid) begin
                        cnt   <= CNT_W'(1);
                        state <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE: begin
                    gmii_tx.en <= 1'b1;
                    if (cnt < CNT_W'(PREAMBLE_LEN)) begin
                        gmii_tx.d <= PREAMBLE_BYTE;
                        cnt       <= cnt + 1'b1;
                    end else begin
                        gmii_tx.d <= SFD_BYTE;
                        len_cnt   <= '0;
                        tx_ready  <= 1'b1;
                        state     <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    gmii_tx.d  <= tx_stream.data;
                    gmii_tx.en <= xfer;
                    if (xfer) begin
                        if (len_cnt < LEN_W'(MIN_DATA_LEN)) begin
                            len_cnt <= len_cnt + 1'b1;
                        end
                        if (tx_stream.last) begin
                            tx_ready <= 1'b0;
                            if (short_frame) begin
                                cnt   <= pad_cnt;
                                state <= TX_PAD;
                            end else begin
                                cnt   <= '0;
                                state <= TX_GAP;
                            end
                        end
                    end
                end
                TX_PAD: begin
                    // Zero fill up to the minimum
                    gmii_tx.d  <= 8'h00;
                    gmii_tx.en <= 1'b1;
                    if (cnt == CNT_W'(1)) begin
                        cnt   <= '0;
                        state <= TX_GAP;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                TX_GAP: begin
                    gmii_tx.en <= 1'b0;
                    cnt        <= cnt + 1'b1;
                    if (cnt == CNT_W'(IFG_BYTES - 1)) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the loopback testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module eth_loop_core_tb \
    -f filelist.f \
    -o eth_loop_sim

./obj_dir/eth_loop_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

//--- source/eth_loop_core.sv
// Multi-port GMII loopback core echoing every good received frame on its own port
`timescale 1ns/1ps

module eth_loop_core #(
    parameter int PORT_CNT      = 2,
    parameter int MAX_FRAME_LEN = 9218,
    parameter int FIFO_DEPTH    = 16384,
    parameter int IFG_BYTES     = 12
) (
    input  logic                clk,
    input  logic                rst_n,
    input  eth_loop_pkg::gmii_t gmii_rx [PORT_CNT],
    output eth_loop_pkg::gmii_t gmii_tx [PORT_CNT]
);

    import eth_loop_pkg::*;

    for (genvar p = 0; p < PORT_CNT; p++) begin : g_port

        axis_byte_t rx_stream;
        logic       rx_valid;
        axis_byte_t tx_stream;
        logic       tx_valid;
        logic       tx_ready;

        // Receive side strips preamble and marks bad frames
        gmii_rx_framer #(
            .MAX_FRAME_LEN(MAX_FRAME_LEN)
        ) rx_framer_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .gmii_rx  (gmii_rx[p]),
            .rx_stream(rx_stream),
            .rx_valid (rx_valid)
        );

        // Whole frames only, bad or oversize ones never leave
        frame_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) fifo_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .rx_stream(rx_stream),
            .rx_valid (rx_valid),
            .tx_stream(tx_stream),
            .tx_valid (tx_valid),
            .tx_ready (tx_ready)
        );

        // Back out on the same port
        gmii_tx_framer #(
            .IFG_BYTES(IFG_BYTES)
        ) tx_framer_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .tx_stream(tx_stream),
            .tx_valid (tx_valid),
            .tx_ready (tx_ready),
            .gmii_tx  (gmii_tx[p])
        );

    end

endmodule

//--- verification/eth_loop_core_tb.sv
// Testbench for the GMII loopback core with per-port frame prediction and checking
`timescale 1ns/1ps

module eth_loop_core_tb;

    import eth_loop_pkg::*;

    localparam int PORT_CNT      = 2;
    localparam int MAX_FRAME_LEN = 200;
    localparam int FIFO_DEPTH    = 128;
    localparam int IFG_BYTES     = 12;
    localparam int CLK_PERIOD    = 100;

    localparam int MIN_DATA_LEN = MIN_FRAME_LEN - FCS_LEN;
    localparam int HDR_LEN      = PREAMBLE_LEN + 1;
    localparam int IN_GAP       = 12;
    localparam int OVERSIZE_MAX = 250;
    // Three burst frames of this size always fit the FIFO together
    localparam int BURST_MIN    = 10;
    localparam int BURST_MAX    = 40;

    // Upper bound on frames sent by all phases
    localparam int MAX_STIM_FRAMES = 40;
    localparam int WATCHDOG_CYCLES =
        3 * MAX_STIM_FRAMES * (HDR_LEN + OVERSIZE_MAX + IN_GAP) + 1000;

    localparam int EXP_BYTES  = 8192;
    localparam int EXP_FRAMES = 64;

    logic  clk;
    logic  rst_n;
    gmii_t gmii_rx [PORT_CNT];
    gmii_t gmii_tx [PORT_CNT];

    // Expected output per port, data already padded
    logic [7:0] exp_data [PORT_CNT][EXP_BYTES];
    int         exp_len [PORT_CNT][EXP_FRAMES];
    int         exp_byte_wr [PORT_CNT];
    int         exp_frame_wr [PORT_CNT];

    int frames_seen [PORT_CNT];
    int value_err_cnt [PORT_CNT];
    int frame_err_cnt [PORT_CNT];
    int gap_err_cnt [PORT_CNT];
    int er_err_cnt [PORT_CNT];

    tb_clock_gen #(
        .PERIOD_NS   (CLK_PERIOD),
        .RESET_CYCLES(3)
    ) clock_gen_inst (
        .clk  (clk),
        .rst_n(rst_n)
    );

    eth_loop_core #(
        .PORT_CNT     (PORT_CNT),
        .MAX_FRAME_LEN(MAX_FRAME_LEN),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .IFG_BYTES    (IFG_BYTES)
    ) eth_loop_core_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .gmii_rx(gmii_rx),
        .gmii_tx(gmii_tx)
    );

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom_range(hi - lo));
    endfunction

    task automatic push_expected(input int p, input logic [7:0] b);
        exp_data[p][exp_byte_wr[p] % EXP_BYTES] = b;
        exp_byte_wr[p]++;
    endtask

    // Preamble, SFD and random data, er high on byte err_at
    task automatic send_frame(input int p, input int len, input int err_at, input bit echoed);
        logic [7:0] data;
        int         i;
        for (i = 0; i < PREAMBLE_LEN; i++) begin
            @(posedge clk);
            gmii_rx[p] <= '{d: PREAMBLE_BYTE, en: 1'b1, er: 1'b0};
        end
        @(posedge clk);
        gmii_rx[p] <= '{d: SFD_BYTE, en: 1'b1, er: 1'b0};
        for (i = 0; i < len; i++) begin
            data = 8'($urandom);
            @(posedge clk);
            gmii_rx[p] <= '{d: data, en: 1'b1, er: (i == err_at)};
            if (echoed) begin
                push_expected(p, data);
            end
        end
        @(posedge clk);
        gmii_rx[p] <= '0;
        if (echoed) begin
            // Short frames come back zero padded
            for (i = len; i < MIN_DATA_LEN; i++) begin
                push_expected(p, 8'h00);
            end
            exp_len[p][exp_frame_wr[p] % EXP_FRAMES] = (len < MIN_DATA_LEN) ? MIN_DATA_LEN : len;
            exp_frame_wr[p]++;
        end
        repeat (IN_GAP) @(posedge clk);
    endtask

    task automatic send_burst(input int p, input int n);
        repeat (n) begin
            send_frame(p, rand_range(BURST_MIN, BURST_MAX), -1, 1'b1);
        end
    endtask

    // All predicted frames seen, so the FIFO is empty and transmit idle
    task automatic wait_idle(input int p);
        while (frames_seen[p] != exp_frame_wr[p]) begin
            @(posedge clk);
        end
        repeat (IFG_BYTES + 4) @(posedge clk);
    endtask

    for (genvar p = 0; p < PORT_CNT; p++) begin : g_monitor
        int         idx = 0;
        int         byte_rd = 0;
        int         frame_rd = 0;
        int         gap_cnt = 0;
        int         cur_len = 0;
        bit         in_frame = 1'b0;
        bit         expected = 1'b0;
        bit         seen_frame = 1'b0;
        int         value_errs = 0;
        int         frame_errs = 0;
        int         gap_errs = 0;
        int         er_errs = 0;
        logic [7:0] exp_byte;

        assign frames_seen[p]   = frame_rd;
        assign value_err_cnt[p] = value_errs;
        assign frame_err_cnt[p] = frame_errs;
        assign gap_err_cnt[p]   = gap_errs;
        assign er_err_cnt[p]    = er_errs;

        // Transmit never signals an error
        assert property (@(posedge clk) disable iff (!rst_n) !gmii_tx[p].er)
        else begin
            $display("FAILED gmii_tx[%0d].er: got %h, expected %h", p, gmii_tx[p].er, 1'b0);
            er_errs++;
        end

        always @(negedge clk) begin
            if (!rst_n) begin
                in_frame   = 1'b0;
                seen_frame = 1'b0;
                assert (!gmii_tx[p].en) else begin
                    $display("FAILED gmii_tx[%0d].en in reset: got %h, expected %h",
                             p, gmii_tx[p].en, 1'b0);
                    frame_errs++;
                end
            end else if (gmii_tx[p].en) begin
                if (!in_frame) begin
                    in_frame = 1'b1;
                    idx      = 0;
                    expected = (frame_rd != exp_frame_wr[p]);
                    cur_len  = expected ? exp_len[p][frame_rd % EXP_FRAMES] : 0;
                    assert (expected) else begin
                        $display("Port %0d transmitted a frame that no received frame explains",
                                 p);
                        frame_errs++;
                    end
                    if (seen_frame) begin
                        assert (gap_cnt >= IFG_BYTES) else begin
                            $display("FAILED gmii_tx[%0d].en low cycles: got %h, expected %h",
                                     p, gap_cnt, IFG_BYTES);
                            gap_errs++;
                        end
                    end
                end
                if (idx < HDR_LEN) begin
                    exp_byte = (idx < PREAMBLE_LEN) ? PREAMBLE_BYTE : SFD_BYTE;
                    assert (gmii_tx[p].d === exp_byte) else begin
                        $display("FAILED gmii_tx[%0d].d in header: got %h, expected %h",
                                 p, gmii_tx[p].d, exp_byte);
                        value_errs++;
                    end
                end else if (idx - HDR_LEN < cur_len) begin
                    exp_byte = exp_data[p][(byte_rd + idx - HDR_LEN) % EXP_BYTES];
                    assert (gmii_tx[p].d === exp_byte) else begin
                        $display("FAILED gmii_tx[%0d].d at byte %0d: got %h, expected %h",
                                 p, idx - HDR_LEN, gmii_tx[p].d, exp_byte);
                        value_errs++;
                    end
                end
                idx++;
            end else if (in_frame) begin
                // Falling en closes the frame
                if (expected) begin
                    assert (idx - HDR_LEN == cur_len) else begin
                        $display("FAILED gmii_tx[%0d] data length: got %h, expected %h",
                                 p, idx - HDR_LEN, cur_len);
                        frame_errs++;
                    end
                    byte_rd += cur_len;
                    frame_rd++;
                end
                in_frame   = 1'b0;
                seen_frame = 1'b1;
                gap_cnt    = 1;
            end else begin
                gap_cnt++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main_seq
        int p;
        int len;
        int value_total;
        int frame_total;
        int gap_total;
        int er_total;
        for (p = 0; p < PORT_CNT; p++) begin
            gmii_rx[p]      = '0;
            exp_byte_wr[p]  = 0;
            exp_frame_wr[p] = 0;
        end
        void'($urandom(83));
        wait (rst_n);
        repeat (2) @(posedge clk);

        // Good frames, echoed unchanged
        for (p = 0; p < PORT_CNT; p++) begin
            wait_idle(p);
            send_frame(p, rand_range(MIN_DATA_LEN, FIFO_DEPTH), -1, 1'b1);
        end

        // Short frames
        for (p = 0; p < PORT_CNT; p++) begin
            repeat (3) begin
                wait_idle(p);
                send_frame(p, rand_range(1, MIN_DATA_LEN - 1), -1, 1'b1);
            end
        end

        // One er cycle drops the frame, the next good one follows
        for (p = 0; p < PORT_CNT; p++) begin
            wait_idle(p);
            len = rand_range(20, 100);
            send_frame(p, len, rand_range(0, len - 1), 1'b0);
            send_frame(p, rand_range(20, MIN_DATA_LEN), -1, 1'b1);
        end

        // Oversize, then a frame too large for the empty FIFO
        for (p = 0; p < PORT_CNT; p++) begin
            wait_idle(p);
            send_frame(p, rand_range(MAX_FRAME_LEN + 1, OVERSIZE_MAX), -1, 1'b0);
            send_frame(p, rand_range(MIN_DATA_LEN, FIFO_DEPTH), -1, 1'b1);
            wait_idle(p);
            send_frame(p, rand_range(FIFO_DEPTH + 1, MAX_FRAME_LEN), -1, 1'b0);
            send_frame(p, rand_range(MIN_DATA_LEN, FIFO_DEPTH), -1, 1'b1);
        end

        // Back-to-back frames on one port at a time
        for (p = 0; p < PORT_CNT; p++) begin
            wait_idle(p);
            send_burst(p, 3);
        end

        // Both ports at once
        for (p = 0; p < PORT_CNT; p++) begin
            wait_idle(p);
        end
        fork
            send_burst(0, 3);
            send_burst(1, 3);
        join
        for (p = 0; p < PORT_CNT; p++) begin
            wait_idle(p);
        end

        value_total = 0;
        frame_total = 0;
        gap_total   = 0;
        er_total    = 0;
        for (p = 0; p < PORT_CNT; p++) begin
            value_total += value_err_cnt[p];
            frame_total += frame_err_cnt[p];
            gap_total   += gap_err_cnt[p];
            er_total    += er_err_cnt[p];
        end
        $display("Errors: value %0d, frame %0d, gap %0d, er %0d",
                 value_total, frame_total, gap_total, er_total);
        if (value_total + frame_total + gap_total + er_total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
// Testbench clock and reset generator with a fixed period and reset length
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Reset held low over the first rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
